//--- build.f
src/lenet_pkg.sv
src/byte_ram.sv
src/bank_switch.sv
src/layer_sequencer.sv
src/max_pool.sv
src/fc_layer.sv
src/result_gather.sv
src/lenet_top.sv
tb/lenet_properties.sv
tb/lenet_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the lenet testbench with verilator, run it, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module lenet_tb \
    -o lenet_sim \
    && ./obj_dir/lenet_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "test passed" sim.log && echo "simulation ok" || exit 1

//--- tb/lenet_tb.sv
`timescale 1ns/1ps

module lenet_tb
    import lenet_pkg::*;
();

    // loads of about 770 cycles plus five runs of about 330
    localparam int max_cycles = 6000;

    logic               clk;
    logic               rst;
    logic               start;
    logic [graph_w-1:0] graph;
    mem_load_t          load;
    result_vec_t        result;
    logic               done;

    // host-side copies of both memories
    logic signed [data_w-1:0] image_mem [input_depth];
    logic signed [data_w-1:0] weight_mem [weight_depth];
    result_vec_t              expected;
    int unsigned              rng_state = 70;
    int                       cycles = 0;

    lenet_top dut0 (
        .clk(clk), .rst(rst), .start(start), .graph(graph),
        .load(load), .result(result), .done(done)
    );

    always #20 clk = ~clk;

    //////////////////////////////
    // checking
    //////////////////////////////
    result_match: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> result == expected)
        else begin
            $display("error: %0t result expected %h got %h", $time, expected, result);
            $display("test failed");
            $fatal(1);
        end

    always @(negedge clk)
    begin
        if (dut0.u_props.violation)
        begin
            $display("a protocol assertion inside the design failed");
            $display("test failed");
            $fatal(1);
        end
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= max_cycles)
        begin
            $display("run timed out after %0d cycles without finishing", cycles);
            $display("test failed");
            $fatal(1);
        end
    end

    function automatic logic [7:0] lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[23:16];
    endfunction

    // 2x2 signed max for pooled value idx of image g
    function automatic logic signed [7:0] pool_value(input int g, input int idx);
        int                r;
        int                c;
        logic signed [7:0] m;
        logic signed [7:0] v;
        r = idx / pool_size;
        c = idx % pool_size;
        m = image_mem[g * img_words + 2 * r * img_size + 2 * c];
        for (int dy = 0; dy < 2; dy++)
            for (int dx = 0; dx < 2; dx++)
            begin
                v = image_mem[g * img_words + (2 * r + dy) * img_size + 2 * c + dx];
                if (v > m)
                    m = v;
            end
        return m;
    endfunction

    // fc with bias, rescale, relu and saturation
    function automatic result_vec_t predict(input int g);
        result_vec_t res;
        int          sum;
        int          scaled;
        res = '0;
        for (int o = 0; o < num_labels; o++)
        begin
            sum = 0;
            for (int i = 0; i < fc_in; i++)
                sum += int'(weight_mem[weight_base + o * fc_in + i]) * int'(pool_value(g, i));
            scaled = (sum >>> frac_bits) + int'(weight_mem[bias_base + o]);
            if (scaled < 0)
                res[o] = 8'd0;
            else if (scaled > 127)
                res[o] = 8'd127;
            else
                res[o] = scaled[7:0];
        end
        return res;
    endfunction

    //////////////////////////////
    // load port
    //////////////////////////////
    task automatic write_byte(input bank_t bank, input int addr, input logic [7:0] data);
        @(negedge clk);
        load.we   = 1'b1;
        load.bank = bank;
        load.addr = addr_w'(addr);
        load.data = data;
        if (bank == bank_input)
            image_mem[addr] = data;
        else
            weight_mem[addr] = data;
    endtask

    task automatic end_load();
        @(negedge clk);
        load = '0;
    endtask

    task automatic load_random_weights();
        logic [7:0] r;
        for (int a = 0; a < weight_depth; a++)
        begin
            r = lcg_next();
            // small biases and weights keep labels below saturation
            if (a < weight_base)
                write_byte(bank_weight, a, {{3{r[4]}}, r[4:0]});
            else
                write_byte(bank_weight, a, {{5{r[2]}}, r[2:0]});
        end
        end_load();
    endtask

    // even labels driven far above 127, odd labels far below 0
    task automatic load_clamp_weights(input int g);
        logic signed [7:0] x;
        for (int a = 0; a < num_labels; a++)
            write_byte(bank_weight, a, 8'd0);
        for (int o = 0; o < num_labels; o++)
            for (int i = 0; i < fc_in; i++)
            begin
                x = pool_value(g, i);
                write_byte(bank_weight, weight_base + o * fc_in + i,
                           ((x < 0) ^ o[0]) ? -8'sd100 : 8'sd100);
            end
        end_load();
    endtask

    task automatic run_inference(input int g);
        expected = predict(g);
        @(negedge clk);
        graph = graph_w'(g);
        start = 1'b1;
        while (!done)
            @(negedge clk);
        // hold start so done and result must stay put
        repeat (3) @(negedge clk);
        start = 1'b0;
        while (done)
            @(negedge clk);
    endtask

    initial
    begin
        clk   = 1'b0;
        rst   = 1'b1;
        start = 1'b0;
        graph = '0;
        load  = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        for (int a = 0; a < input_depth; a++)
            write_byte(bank_input, a, lcg_next());
        end_load();
        load_random_weights();

        run_inference(0);
        run_inference(3);
        run_inference(1);
        load_clamp_weights(2);
        run_inference(2);
        load_random_weights();
        run_inference(2);

        repeat (2) @(negedge clk);
        if (dut0.u_props.violation)
        begin
            $display("test failed");
            $fatal(1);
        end
        else
        begin
            $display("test passed");
            $finish;
        end
    end

endmodule

//--- tb/lenet_properties.sv
`timescale 1ns/1ps

module lenet_properties
    import lenet_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        start,
    input logic        done,
    input result_vec_t result,
    input logic        pool_req,
    input logic        pool_ack,
    input logic        fc_req,
    input logic        fc_ack,
    input logic        gather_req,
    input logic        gather_ack
);

    // set once any check below has fired
    logic violation = 1'b0;

    //////////////////////////////
    // reset state
    //////////////////////////////
    reset_state: assert property (@(posedge clk)
        $fell(rst) |-> !done && result == '0 && !pool_req && !fc_req && !gather_req)
        else begin $error("outputs not cleared after reset"); violation = 1'b1; end

    //////////////////////////////
    // top-level start/done
    //////////////////////////////
    done_needs_start: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> start)
        else begin $error("done rose while start was low"); violation = 1'b1; end

    done_holds: assert property (@(posedge clk) disable iff (rst)
        done && start |=> done && $stable(result))
        else begin $error("done or result moved while start held"); violation = 1'b1; end

    done_release: assert property (@(posedge clk) disable iff (rst)
        done && !start |=> !done)
        else begin $error("done did not fall after start dropped"); violation = 1'b1; end

    // stage handshakes
    one_req: assert property (@(posedge clk) disable iff (rst)
        $onehot0({pool_req, fc_req, gather_req}))
        else begin $error("more than one stage req high"); violation = 1'b1; end

    pool_ack_in_req: assert property (@(posedge clk) disable iff (rst)
        $rose(pool_ack) |-> pool_req)
        else begin $error("pool ack rose without req"); violation = 1'b1; end

    fc_ack_in_req: assert property (@(posedge clk) disable iff (rst)
        $rose(fc_ack) |-> fc_req)
        else begin $error("fc ack rose without req"); violation = 1'b1; end

    gather_ack_in_req: assert property (@(posedge clk) disable iff (rst)
        $rose(gather_ack) |-> gather_req)
        else begin $error("gather ack rose without req"); violation = 1'b1; end

endmodule

bind lenet_top lenet_properties u_props (
    .clk(clk), .rst(rst), .start(start), .done(done), .result(result),
    .pool_req(pool_req), .pool_ack(pool_ack),
    .fc_req(fc_req), .fc_ack(fc_ack),
    .gather_req(gather_req), .gather_ack(gather_ack)
);

//--- src/lenet_top.sv
`timescale 1ns/1ps

module lenet_top
    import lenet_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic [graph_w-1:0] graph,
    input  mem_load_t          load,
    output result_vec_t        result,
    output logic               done
);

    logic [addr_w-1:0] graph_base;
    stage_t            stage;
    logic              pool_req, pool_ack;
    logic              fc_req, fc_ack;
    logic              gather_req, gather_ack;
    result_vec_t       gather_result;

    // per-stage memory requests
    mem_req_t pool_rd, pool_wr;
    mem_req_t fc_w_rd, fc_x_rd, fc_wr;
    mem_req_t gather_rd;

    // memory side
    mem_req_t          input_port, weight_port, scratch_port;
    logic [data_w-1:0] input_rdata, weight_rdata, scratch_rdata;

    layer_sequencer u_sequencer (
        .clk(clk), .rst(rst), .start(start), .graph(graph),
        .graph_base(graph_base), .stage(stage),
        .pool_req(pool_req), .pool_ack(pool_ack),
        .fc_req(fc_req), .fc_ack(fc_ack),
        .gather_req(gather_req), .gather_ack(gather_ack),
        .gather_result(gather_result), .result(result), .done(done)
    );

    bank_switch u_bank_switch (
        .stage(stage), .load(load),
        .pool_rd(pool_rd), .pool_wr(pool_wr),
        .fc_rd(fc_w_rd), .fc_x_rd(fc_x_rd), .fc_wr(fc_wr),
        .gather_rd(gather_rd),
        .input_port(input_port), .weight_port(weight_port),
        .scratch_port(scratch_port)
    );

    byte_ram #(.depth(input_depth)) input_ram (
        .clk(clk), .port(input_port), .rdata(input_rdata)
    );

    byte_ram #(.depth(weight_depth)) weight_ram (
        .clk(clk), .port(weight_port), .rdata(weight_rdata)
    );

    byte_ram #(.depth(scratch_depth)) scratch_ram (
        .clk(clk), .port(scratch_port), .rdata(scratch_rdata)
    );

    max_pool u_max_pool (
        .clk(clk), .rst(rst), .req(pool_req), .ack(pool_ack),
        .graph_base(graph_base), .in_rd(pool_rd), .in_rdata(input_rdata),
        .out_wr(pool_wr)
    );

    fc_layer u_fc_layer (
        .clk(clk), .rst(rst), .req(fc_req), .ack(fc_ack),
        .w_rd(fc_w_rd), .w_rdata(weight_rdata),
        .x_rd(fc_x_rd), .x_rdata(scratch_rdata), .out_wr(fc_wr)
    );

    result_gather u_result_gather (
        .clk(clk), .rst(rst), .req(gather_req), .ack(gather_ack),
        .rd(gather_rd), .rdata(scratch_rdata), .result(gather_result)
    );

endmodule

//--- src/result_gather.sv
`timescale 1ns/1ps

module result_gather
    import lenet_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    output logic              ack,
    output mem_req_t          rd,
    input  logic [data_w-1:0] rdata,
    output result_vec_t       result
);

    logic [3:0] cnt;
    logic       busy;

    assign busy = req && !ack;

    always_comb
    begin
        rd.en    = busy && (cnt < 4'(num_labels));
        rd.we    = 1'b0;
        rd.addr  = addr_w'(fc_out_base) + addr_w'(cnt);
        rd.wdata = '0;
    end

    always_ff @(posedge clk)
    begin
        if (rst || !req)
        begin
            cnt <= '0;
            ack <= 1'b0;
        end
        else if (!ack)
        begin
            if (cnt == 4'(num_labels))
                ack <= 1'b1;
            else
                cnt <= cnt + 4'd1;
        end
    end

    // shift in from the top so label 0 ends in the lowest byte
    always_ff @(posedge clk)
    begin
        if (busy && cnt != '0)
            result <= {rdata, result[num_labels-1:1]};
    end

endmodule

//--- src/fc_layer.sv
`timescale 1ns/1ps

module fc_layer
    import lenet_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    output logic              ack,
    output mem_req_t          w_rd,
    input  logic [data_w-1:0] w_rdata,
    output mem_req_t          x_rd,
    input  logic [data_w-1:0] x_rdata,
    output mem_req_t          out_wr
);

    // phase 0..15 fetch a weight and a pooled value
    // phase 16 fetches the bias and phase 17 writes the output
    logic [4:0]                 phase;
    logic [3:0]                 out_idx;
    logic                       busy;
    logic signed [2*data_w-1:0] product;
    logic signed [acc_w-1:0]    acc;
    logic signed [acc_w-1:0]    scaled;
    logic [data_w-1:0]          clamped;
    logic                       bias_phase;

    assign busy       = req && !ack;
    assign bias_phase = (phase == 5'(fc_in));
    assign product    = $signed(w_rdata) * $signed(x_rdata);

    //////////////////////////////
    // rescale, relu, saturate
    //////////////////////////////
    always_comb
    begin
        scaled = (acc >>> frac_bits) + acc_w'($signed(w_rdata));
        if (scaled < 0)
            clamped = '0;
        else if (scaled > sat_max)
            clamped = data_w'(sat_max);
        else
            clamped = scaled[data_w-1:0];
    end

    always_comb
    begin
        w_rd.en      = busy && (phase <= 5'(fc_in));
        w_rd.we      = 1'b0;
        if (bias_phase)
            w_rd.addr = addr_w'(bias_base) + addr_w'(out_idx);
        else
            w_rd.addr = addr_w'(weight_base) + addr_w'(out_idx) * addr_w'(fc_in)
                        + addr_w'(phase);
        w_rd.wdata   = '0;
        x_rd.en      = busy && (phase < 5'(fc_in));
        x_rd.we      = 1'b0;
        x_rd.addr    = addr_w'(phase);
        x_rd.wdata   = '0;
        out_wr.en    = busy && (phase == 5'(fc_in + 1));
        out_wr.we    = 1'b1;
        out_wr.addr  = addr_w'(fc_out_base) + addr_w'(out_idx);
        out_wr.wdata = clamped;
    end

    always_ff @(posedge clk)
    begin
        if (rst || !req)
        begin
            phase   <= '0;
            out_idx <= '0;
            ack     <= 1'b0;
        end
        else if (!ack)
        begin
            if (phase == 5'(fc_in + 1))
            begin
                phase   <= '0;
                out_idx <= out_idx + 4'd1;
                if (out_idx == 4'(num_labels - 1))
                    ack <= 1'b1;
            end
            else
                phase <= phase + 5'd1;
        end
    end

    // products land one cycle after their fetch
    always_ff @(posedge clk)
    begin
        if (phase == 5'd1)
            acc <= acc_w'(product);
        else if (phase > 5'd1 && phase <= 5'(fc_in))
            acc <= acc + acc_w'(product);
    end

endmodule

//--- src/max_pool.sv
`timescale 1ns/1ps

module max_pool
    import lenet_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    output logic              ack,
    input  logic [addr_w-1:0] graph_base,
    output mem_req_t          in_rd,
    input  logic [data_w-1:0] in_rdata,
    output mem_req_t          out_wr
);

    // phase 0..3 issue reads, 1..4 take data, 5 writes
    logic [2:0]               phase;
    logic [3:0]               out_idx;
    logic [1:0]               row, col, win;
    logic [addr_w-1:0]        win_row, win_col;
    logic signed [data_w-1:0] best;
    logic                     busy;

    assign busy    = req && !ack;
    assign row     = out_idx[3:2];
    assign col     = out_idx[1:0];
    assign win     = phase[1:0];
    assign win_row = addr_w'({row, win[1]});
    assign win_col = addr_w'({col, win[0]});

    always_comb
    begin
        in_rd.en     = busy && (phase < 3'd4);
        in_rd.we     = 1'b0;
        in_rd.addr   = graph_base + win_row * addr_w'(img_size) + win_col;
        in_rd.wdata  = '0;
        out_wr.en    = busy && (phase == 3'd5);
        out_wr.we    = 1'b1;
        out_wr.addr  = addr_w'(row) * addr_w'(pool_size) + addr_w'(col);
        out_wr.wdata = best;
    end

    always_ff @(posedge clk)
    begin
        if (rst || !req)
        begin
            phase   <= '0;
            out_idx <= '0;
            ack     <= 1'b0;
        end
        else if (!ack)
        begin
            if (phase == 3'd5)
            begin
                phase   <= '0;
                out_idx <= out_idx + 4'd1;
                if (out_idx == 4'(fc_in - 1))
                    ack <= 1'b1;
            end
            else
                phase <= phase + 3'd1;
        end
    end

    // signed running max over the window
    always_ff @(posedge clk)
    begin
        if (phase == 3'd1)
            best <= $signed(in_rdata);
        else if (phase >= 3'd2 && phase <= 3'd4 && $signed(in_rdata) > best)
            best <= $signed(in_rdata);
    end

endmodule

//--- src/layer_sequencer.sv
`timescale 1ns/1ps

module layer_sequencer
    import lenet_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic [graph_w-1:0] graph,
    output logic [addr_w-1:0]  graph_base,
    output stage_t             stage,
    output logic               pool_req,
    input  logic               pool_ack,
    output logic               fc_req,
    input  logic               fc_ack,
    output logic               gather_req,
    input  logic               gather_ack,
    input  result_vec_t        gather_result,
    output result_vec_t        result,
    output logic               done
);

    // each stage raises req, waits for ack, drops req and waits for ack to fall
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            stage      <= stage_idle;
            graph_base <= '0;
            pool_req   <= 1'b0;
            fc_req     <= 1'b0;
            gather_req <= 1'b0;
            result     <= '0;
        end
        else
        begin
            case (stage)
                stage_idle:
                begin
                    if (start)
                    begin
                        graph_base <= addr_w'(graph) * addr_w'(img_words);
                        pool_req   <= 1'b1;
                        stage      <= stage_pool;
                    end
                end
                stage_pool:
                begin
                    if (pool_req && pool_ack)
                        pool_req <= 1'b0;
                    else if (!pool_req && !pool_ack)
                    begin
                        fc_req <= 1'b1;
                        stage  <= stage_fc;
                    end
                end
                stage_fc:
                begin
                    if (fc_req && fc_ack)
                        fc_req <= 1'b0;
                    else if (!fc_req && !fc_ack)
                    begin
                        gather_req <= 1'b1;
                        stage      <= stage_gather;
                    end
                end
                stage_gather:
                begin
                    if (gather_req && gather_ack)
                        gather_req <= 1'b0;
                    else if (!gather_req && !gather_ack)
                    begin
                        result <= gather_result;
                        stage  <= stage_finish;
                    end
                end
                stage_finish:
                begin
                    // host drops start to release us
                    if (!start)
                        stage <= stage_idle;
                end
                default:
                    stage <= stage_idle;
            endcase
        end
    end

    assign done = (stage == stage_finish);

endmodule

//--- src/bank_switch.sv
`timescale 1ns/1ps

module bank_switch
    import lenet_pkg::*;
(
    input  stage_t    stage,
    input  mem_load_t load,
    input  mem_req_t  pool_rd,
    input  mem_req_t  pool_wr,
    input  mem_req_t  fc_rd,
    input  mem_req_t  fc_x_rd,
    input  mem_req_t  fc_wr,
    input  mem_req_t  gather_rd,
    output mem_req_t  input_port,
    output mem_req_t  weight_port,
    output mem_req_t  scratch_port
);

    mem_req_t load_req;

    // load port as a plain write
    always_comb
    begin
        load_req.en    = load.we;
        load_req.we    = load.we;
        load_req.addr  = load.addr;
        load_req.wdata = load.data;
    end

    //////////////////////////////
    // routing by active stage
    //////////////////////////////
    always_comb
    begin
        input_port   = '0;
        weight_port  = '0;
        scratch_port = '0;
        case (stage)
            stage_idle:
            begin
                if (load.bank == bank_input)
                    input_port = load_req;
                else
                    weight_port = load_req;
            end
            stage_pool:
            begin
                input_port   = pool_rd;
                scratch_port = pool_wr;
            end
            stage_fc:
            begin
                weight_port = fc_rd;
                // fc never reads and writes scratch in one cycle
                if (fc_wr.en)
                    scratch_port = fc_wr;
                else
                    scratch_port = fc_x_rd;
            end
            stage_gather:
                scratch_port = gather_rd;
            default:
            begin
                input_port   = '0;
                weight_port  = '0;
                scratch_port = '0;
            end
        endcase
    end

endmodule

//--- src/byte_ram.sv
`timescale 1ns/1ps

module byte_ram
    import lenet_pkg::*;
#(
    parameter int depth = 256
)
(
    input  logic              clk,
    input  mem_req_t          port,
    output logic [data_w-1:0] rdata
);

    localparam int idx_w = $clog2(depth);

    logic [data_w-1:0] mem [depth];

    // read data valid one cycle after an enabled read
    always_ff @(posedge clk)
    begin
        if (port.en)
        begin
            if (port.we)
                mem[port.addr[idx_w-1:0]] <= port.wdata;
            else
                rdata <= mem[port.addr[idx_w-1:0]];
        end
    end

endmodule

//--- src/lenet_pkg.sv
package lenet_pkg;

    //////////////////////////////
    // network sizes
    //////////////////////////////
    localparam int data_w      = 8;
    localparam int img_size    = 8;
    localparam int pool_size   = 4;
    localparam int fc_in       = 16;
    localparam int num_labels  = 10;
    localparam int num_graphs  = 4;
    localparam int graph_w     = $clog2(num_graphs);
    localparam int img_words   = img_size * img_size;

    // fixed point
    localparam int frac_bits   = 4;
    localparam int acc_w       = 2 * data_w + $clog2(fc_in) + 1;
    localparam int sat_max     = 2 ** (data_w - 1) - 1;

    //////////////////////////////
    // memory map
    //////////////////////////////
    localparam int addr_w        = 8;
    localparam int bias_base     = 0;
    localparam int weight_base   = num_labels;
    localparam int fc_out_base   = fc_in;
    localparam int input_depth   = num_graphs * img_words;
    localparam int weight_depth  = weight_base + num_labels * fc_in;
    localparam int scratch_depth = 32;

    typedef struct packed {
        logic              en;
        logic              we;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
    } mem_req_t;

    typedef enum logic {bank_input, bank_weight} bank_t;

    typedef struct packed {
        logic              we;
        bank_t             bank;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
    } mem_load_t;

    typedef enum logic [2:0] {
        stage_idle, stage_pool, stage_fc, stage_gather, stage_finish
    } stage_t;

    // label 0 in the lowest byte
    typedef logic signed [num_labels-1:0][data_w-1:0] result_vec_t;

endpackage
